//--- Bender.yml
package:
  name: eeprom_ctrl

sources:
  - src/eeprom_pkg.sv
  - src/i2c_bit_engine.sv
  - src/eeprom_sequencer.sv
  - src/eeprom_ctrl_top.sv
  - target: test
    files:
      - tests/eeprom_slave_model.sv
      - tests/tb_eeprom_ctrl.sv

//--- list.f
src/eeprom_pkg.sv
src/i2c_bit_engine.sv
src/eeprom_sequencer.sv
src/eeprom_ctrl_top.sv
tests/eeprom_slave_model.sv
tests/tb_eeprom_ctrl.sv

//--- src/eeprom_ctrl_top.sv
`timescale 1ns/10ps
module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          done,
    output logic                          busy,
    output logic                          nack_err,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          scl,
    inout  wire                           sda
);

    logic                    req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic                    seq_busy;
    logic                    cmd_start;
    logic                    cmd_done;
    eeprom_pkg::bit_cmd_t    cmd;
    eeprom_pkg::bit_rsp_t    rsp;
    logic                    sda_oe;

    // strobes during busy are dropped
    always_ff @(posedge CLK)
    begin
        if (RESET)
            req_valid <= 1'b0;
        else
            req_valid <= (wr || rd) && !busy;
    end

    always_ff @(posedge CLK)
    begin
        if ((wr || rd) && !busy)
        begin
            req.is_read <= ~wr;  // wr wins over rd
            req.addr    <= addr;
            req.wdata   <= wdata;
        end
    end

    assign busy = seq_busy | req_valid;

    assign sda = sda_oe ? 1'b0 : 1'bz;  // open drain

    eeprom_sequencer eeprom_sequencer_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .cmd_done  (cmd_done),
        .rsp       (rsp),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .busy      (seq_busy),
        .done      (done),
        .rdata     (rdata),
        .nack_err  (nack_err)
    );

    i2c_bit_engine i2c_bit_engine_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .sda_in    (sda),
        .cmd_done  (cmd_done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

//--- src/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // CLK cycles per SCL bit
    localparam int QUARTERS = 4;

    typedef struct packed {
        logic              is_read;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } eeprom_req_t;

    // CMD_START doubles as repeated start
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } bit_cmd_e;

    typedef struct packed {
        bit_cmd_e          cmd;
        logic [DATA_W-1:0] tx_byte;
        logic              master_ack;  // level driven in the 9th bit of a read
    } bit_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] rx_byte;
        logic              slave_nack;
    } bit_rsp_t;

endpackage

//--- src/eeprom_sequencer.sv
`timescale 1ns/10ps
module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req_valid,
    input  eeprom_pkg::eeprom_req_t       req,
    input  logic                          cmd_done,
    input  eeprom_pkg::bit_rsp_t          rsp,
    output logic                          cmd_start,
    output eeprom_pkg::bit_cmd_t          cmd,
    output logic                          busy,
    output logic                          done,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          nack_err
);

    typedef enum logic [9:0] {
        S_IDLE    = 10'b00_0000_0001,
        S_READY   = 10'b00_0000_0010,
        S_START   = 10'b00_0000_0100,
        S_CTRL    = 10'b00_0000_1000,
        S_ADDR    = 10'b00_0001_0000,
        S_DATA    = 10'b00_0010_0000,
        S_RESTART = 10'b00_0100_0000,
        S_CTRL_RD = 10'b00_1000_0000,
        S_READ    = 10'b01_0000_0000,
        S_STOP    = 10'b10_0000_0000
    } state_e;

    state_e                        state;
    eeprom_pkg::eeprom_req_t       req_q;
    logic                          err;
    logic [eeprom_pkg::DATA_W-1:0] rx_q;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_wr;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_rd;

    // device code, block select from addr[10:8], r/w bit
    assign ctrl_wr = {eeprom_pkg::DEV_TYPE,
                      req_q.addr[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W], 1'b0};
    assign ctrl_rd = {eeprom_pkg::DEV_TYPE,
                      req_q.addr[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W], 1'b1};

    function automatic eeprom_pkg::bit_cmd_t mk_cmd(
        input eeprom_pkg::bit_cmd_e          c,
        input logic [eeprom_pkg::DATA_W-1:0] b,
        input logic                          ack
    );
        eeprom_pkg::bit_cmd_t r;
        r.cmd        = c;
        r.tx_byte    = b;
        r.master_ack = ack;
        return r;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && req_valid)
            req_q <= req;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_start <= 1'b0;
            cmd       <= mk_cmd(eeprom_pkg::CMD_STOP, '0, 1'b1);
            busy      <= 1'b0;
            done      <= 1'b0;
            err       <= 1'b0;
            rx_q      <= '0;
            rdata     <= '0;
            nack_err  <= 1'b0;
        end
        else
        begin
            cmd_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                S_IDLE:
                    if (req_valid)
                    begin
                        busy  <= 1'b1;
                        err   <= 1'b0;
                        state <= S_READY;
                    end
                S_READY:
                begin
                    cmd       <= mk_cmd(eeprom_pkg::CMD_START, '0, 1'b1);
                    cmd_start <= 1'b1;
                    state     <= S_START;
                end
                S_START:
                    if (cmd_done)
                    begin
                        cmd       <= mk_cmd(eeprom_pkg::CMD_WRITE, ctrl_wr, 1'b1);
                        cmd_start <= 1'b1;
                        state     <= S_CTRL;
                    end
                S_CTRL:
                    if (cmd_done)
                    begin
                        cmd <= mk_cmd(eeprom_pkg::CMD_WRITE,
                                      req_q.addr[eeprom_pkg::DATA_W-1:0], 1'b1);
                        cmd_start <= 1'b1;
                        state     <= S_ADDR;
                    end
                S_ADDR:
                    if (cmd_done)
                    begin
                        cmd_start <= 1'b1;
                        if (req_q.is_read)
                        begin
                            cmd   <= mk_cmd(eeprom_pkg::CMD_START, '0, 1'b1);
                            state <= S_RESTART;
                        end
                        else
                        begin
                            cmd   <= mk_cmd(eeprom_pkg::CMD_WRITE, req_q.wdata, 1'b1);
                            state <= S_DATA;
                        end
                    end
                S_DATA, S_READ:
                    if (cmd_done)
                    begin
                        if (state == S_READ)
                            rx_q <= rsp.rx_byte;
                        cmd       <= mk_cmd(eeprom_pkg::CMD_STOP, '0, 1'b1);
                        cmd_start <= 1'b1;
                        state     <= S_STOP;
                    end
                S_RESTART:
                    if (cmd_done)
                    begin
                        cmd       <= mk_cmd(eeprom_pkg::CMD_WRITE, ctrl_rd, 1'b1);
                        cmd_start <= 1'b1;
                        state     <= S_CTRL_RD;
                    end
                S_CTRL_RD:
                    if (cmd_done)
                    begin
                        cmd       <= mk_cmd(eeprom_pkg::CMD_READ, '0, 1'b1);  // single byte, nack
                        cmd_start <= 1'b1;
                        state     <= S_READ;
                    end
                S_STOP:
                    if (cmd_done)
                    begin
                        done     <= 1'b1;
                        busy     <= 1'b0;
                        rdata    <= rx_q;
                        nack_err <= err;
                        state    <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase

            // missing ack on any written byte goes straight to stop
            if (cmd_done && rsp.slave_nack)
            begin
                err       <= 1'b1;
                cmd       <= mk_cmd(eeprom_pkg::CMD_STOP, '0, 1'b1);
                cmd_start <= 1'b1;
                state     <= S_STOP;
            end
        end
    end

endmodule

//--- src/i2c_bit_engine.sv
`timescale 1ns/10ps
module i2c_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_start,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 sda_in,
    output logic                 cmd_done,
    output eeprom_pkg::bit_rsp_t rsp,
    output logic                 scl,
    output logic                 sda_oe
);

    logic                                   active;
    eeprom_pkg::bit_cmd_e                   op;
    logic [$clog2(eeprom_pkg::QUARTERS)-1:0] q;      // quarter within the current bit
    logic [3:0]                             bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0]          shreg;
    logic                                   mack;
    logic                                   nack;
    logic                                   is_byte;
    logic                                   q_last;
    logic                                   q_mid;
    logic                                   bit_last;
    logic                                   accept;

    assign accept   = cmd_start && !active;
    assign is_byte  = (op == eeprom_pkg::CMD_WRITE) || (op == eeprom_pkg::CMD_READ);
    assign q_last   = (int'(q) == eeprom_pkg::QUARTERS - 1);
    assign q_mid    = (int'(q) == eeprom_pkg::QUARTERS / 2);  // first quarter with scl high
    assign bit_last = is_byte ? (bit_cnt == 4'd8) : (bit_cnt == 4'd0);

    // last cycle of the primitive
    assign cmd_done = active && q_last && bit_last;

    assign rsp.rx_byte    = shreg;
    assign rsp.slave_nack = nack;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            op      <= eeprom_pkg::CMD_START;
            q       <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            nack    <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_start)
            begin
                active  <= 1'b1;
                op      <= cmd.cmd;
                q       <= '0;
                bit_cnt <= '0;
                scl     <= 1'b0;
                nack    <= 1'b0;
                case (cmd.cmd)
                    eeprom_pkg::CMD_STOP:  sda_oe <= 1'b1;  // low before scl rises
                    eeprom_pkg::CMD_WRITE: sda_oe <= ~cmd.tx_byte[eeprom_pkg::DATA_W-1];
                    default:               sda_oe <= 1'b0;
                endcase
            end
        end
        else if (q_last)
        begin
            if (bit_last)
            begin
                active <= 1'b0;  // scl left high until the next primitive
            end
            else
            begin
                q       <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                scl     <= 1'b0;
                if (bit_cnt == 4'd7)
                begin
                    // ack bit: master answers on a read, slave on a write
                    sda_oe <= (op == eeprom_pkg::CMD_READ) ? ~mack : 1'b0;
                end
                else
                begin
                    sda_oe <= (op == eeprom_pkg::CMD_WRITE) ?
                              ~shreg[eeprom_pkg::DATA_W-2] : 1'b0;
                end
            end
        end
        else
        begin
            q <= q + 1'b1;
            if (int'(q) == eeprom_pkg::QUARTERS / 2 - 1)
                scl <= 1'b1;
            if (q_mid)
            begin
                // start and stop move sda while scl is high
                if (op == eeprom_pkg::CMD_START)
                    sda_oe <= 1'b1;
                else if (op == eeprom_pkg::CMD_STOP)
                    sda_oe <= 1'b0;
                if (op == eeprom_pkg::CMD_WRITE && bit_cnt == 4'd8)
                    nack <= sda_in;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            shreg <= cmd.tx_byte;
            mack  <= cmd.master_ack;
        end
        else if (active && bit_cnt < 4'd8)
        begin
            if (op == eeprom_pkg::CMD_READ && q_mid)
                shreg <= {shreg[eeprom_pkg::DATA_W-2:0], sda_in};  // msb first
            else if (op == eeprom_pkg::CMD_WRITE && q_last)
                shreg <= {shreg[eeprom_pkg::DATA_W-2:0], 1'b0};
        end
    end

endmodule

//--- tests/eeprom_slave_model.sv
`timescale 1ns/10ps
module eeprom_slave_model (
    input  logic CLK,      // oversampling clock, scl and sda are settled at its falling edge
    input  logic scl,
    inout  wire  sda,
    input  logic respond   // low makes the device ignore its address
);

    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        sda_s;
    logic        sda_low;
    logic        in_frame;
    logic        addressed;
    logic        rw;
    logic        sending;
    logic [3:0]  nbits;     // scl rising edges seen in the current byte
    logic [3:0]  n;
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  rx;
    logic [2:0]  blk;
    logic [10:0] ptr;

    assign sda   = sda_low ? 1'b0 : 1'bz;
    assign sda_s = (sda !== 1'b0);
    assign rx    = {shreg[6:0], sda_s};
    assign n     = (nbits == 4'd9) ? 4'd0 : nbits;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'((i >> 8) * 37);
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        sda_low   = 1'b0;
        in_frame  = 1'b0;
        addressed = 1'b0;
        rw        = 1'b0;
        sending   = 1'b0;
        nbits     = 4'd0;
        byte_idx  = 2'd0;
        shreg     = 8'h00;
        blk       = 3'd0;
        ptr       = 11'd0;
    end

    always @(negedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda_s;
        if (scl && scl_q && sda_q && !sda_s)
        begin
            // start or repeated start
            in_frame  <= 1'b1;
            addressed <= 1'b0;
            rw        <= 1'b0;
            sending   <= 1'b0;
            nbits     <= 4'd0;
            byte_idx  <= 2'd0;
            sda_low   <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda_s)
        begin
            in_frame <= 1'b0;  // stop
            sda_low  <= 1'b0;
        end
        else if (in_frame && scl && !scl_q)
        begin
            nbits <= nbits + 4'd1;
            shreg <= rx;
            if (!sending && nbits == 4'd7)
            begin
                if (byte_idx != 2'd2)
                    byte_idx <= byte_idx + 2'd1;
                case (byte_idx)
                    2'd0:
                    begin
                        addressed <= respond && (rx[7:4] == 4'b1010);
                        rw        <= rx[0];
                        blk       <= rx[3:1];
                        ptr[10:8] <= rx[3:1];  // block select
                    end
                    2'd1:
                        ptr <= {blk, rx};
                    default:
                        if (addressed)
                        begin
                            mem[ptr] <= rx;
                            ptr      <= ptr + 11'd1;
                        end
                endcase
            end
            if (sending && nbits == 4'd8)
            begin
                if (sda_s)
                    in_frame <= 1'b0;  // master nack ends the read
                else
                    ptr <= ptr + 11'd1;
            end
        end
        else if (in_frame && !scl && scl_q)
        begin
            if (nbits == 4'd9)
            begin
                nbits   <= 4'd0;
                sending <= rw;
            end
            if (n == 4'd8)
                sda_low <= !sending && addressed;  // ack slot
            else if ((nbits == 4'd9) ? rw : sending)
                sda_low <= !mem[ptr][7 - n];
            else
                sda_low <= 1'b0;
        end
    end

endmodule

//--- tests/tb_eeprom_ctrl.sv
`timescale 1ns/10ps
module tb_eeprom_ctrl;

    // 40 transactions of at most 45 bit times each
    localparam int TIMEOUT = 40 * 45 * eeprom_pkg::QUARTERS;

    logic                          CLK;
    logic                          RESET;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    logic                          done;
    logic                          busy;
    logic                          nack_err;
    logic [eeprom_pkg::DATA_W-1:0] rdata;
    logic                          scl;
    wire                           sda;
    logic                          respond;

    logic [eeprom_pkg::DATA_W-1:0] sb [0:2047];  // last value written per address
    logic [eeprom_pkg::ADDR_W-1:0] used [$];
    int seed = 92;
    int cycles = 0;
    int errs = 0;
    int done_cnt = 0;
    int n_pass = 0;
    int n_fail = 0;

    pullup (sda);

    eeprom_ctrl_top eeprom_ctrl_top_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .done     (done),
        .busy     (busy),
        .nack_err (nack_err),
        .rdata    (rdata),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_slave_model eeprom_slave_model_i (
        .CLK     (CLK),
        .scl     (scl),
        .sda     (sda),
        .respond (respond)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    always @(negedge CLK)
    begin
        if (done)
            done_cnt++;
    end

    // sda may only move with scl high for a start or a stop
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $fell(sda))
            |-> eeprom_ctrl_top_i.i2c_bit_engine_i.op == eeprom_pkg::CMD_START)
    else
    begin
        errs++;
        $display("sda fell while scl was high outside a start condition");
    end

    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $rose(sda))
            |-> eeprom_ctrl_top_i.i2c_bit_engine_i.op == eeprom_pkg::CMD_STOP)
    else
    begin
        errs++;
        $display("sda rose while scl was high outside a stop condition");
    end

    assert property (@(posedge CLK) disable iff (RESET) ((wr || rd) && !busy) |=> busy)
    else
    begin
        errs++;
        $display("busy did not rise after an accepted strobe");
    end

    assert property (@(posedge CLK) disable iff (RESET) (busy && !done) |=> (busy || done))
    else
    begin
        errs++;
        $display("busy dropped without a done pulse");
    end

    task automatic strobe(input logic is_rd, input logic [10:0] a, input logic [7:0] d);
        @(negedge CLK);
        wr    = !is_rd;
        rd    = is_rd;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done();
        while (!done)
            @(negedge CLK);
    endtask

    task automatic write_byte(input string name, input logic [10:0] a, input logic [7:0] d);
        strobe(1'b0, a, d);
        wait_done();
        sb[a] = d;
        assert (nack_err == 1'b0)
        else
        begin
            errs++;
            $display("MISMATCH %s: nack_err expected 0, actual %b", name, nack_err);
        end
    endtask

    task automatic read_check(input string name, input logic [10:0] a);
        strobe(1'b1, a, 8'h00);
        wait_done();
        assert (rdata === sb[a] && nack_err == 1'b0)
        else
        begin
            errs++;
            $display("MISMATCH %s: addr %03h expected %02h, actual %02h (nack_err %b)",
                     name, a, sb[a], rdata, nack_err);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errs == errs_before)
        begin
            n_pass++;
            $display("test %s: ok", name);
        end
        else
        begin
            n_fail++;
            $display("test %s: failed", name);
        end
    endtask

    initial
    begin
        int          e;
        int          dones;
        logic [10:0] a;
        logic [7:0]  d;

        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        respond = 1'b1;
        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);

        e = errs;
        assert ({scl, sda, busy, done, nack_err} === 5'b11000)
        else
        begin
            errs++;
            $display("MISMATCH reset: {scl,sda,busy,done,nack_err} expected 11000, actual %b",
                     {scl, sda, busy, done, nack_err});
        end
        end_test("reset", e);

        e = errs;
        write_byte("basic", 11'h123, 8'h5A);
        read_check("basic", 11'h123);
        end_test("basic", e);

        // same word address, different block
        e = errs;
        write_byte("block", 11'h045, 8'hC3);
        write_byte("block", 11'h745, 8'h3C);
        read_check("block", 11'h045);
        read_check("block", 11'h745);
        end_test("block", e);

        e = errs;
        for (int i = 0; i < 12; i++)
        begin
            a = 11'($random(seed)) & 11'h70F;  // narrow range so addresses repeat
            d = 8'($random(seed));
            write_byte("random", a, d);
            used.push_back(a);
        end
        for (int i = 11; i >= 0; i--)
            read_check("random", used[i]);
        end_test("random", e);

        e = errs;
        strobe(1'b0, 11'h2B7, 8'h96);
        dones = done_cnt;
        sb[11'h2B7] = 8'h96;
        repeat (4) @(negedge CLK);
        strobe(1'b0, 11'h2B7, 8'h69);  // arrives while busy
        wait_done();
        repeat (200) @(negedge CLK);
        assert (done_cnt - dones == 1)
        else
        begin
            errs++;
            $display("MISMATCH busy: done pulses expected 1, actual %0d", done_cnt - dones);
        end
        read_check("busy", 11'h2B7);
        end_test("busy", e);

        e = errs;
        respond = 1'b0;
        strobe(1'b0, 11'h0F0, 8'hE1);
        wait_done();
        assert (nack_err == 1'b1)
        else
        begin
            errs++;
            $display("MISMATCH nack: nack_err expected 1, actual %b", nack_err);
        end
        @(negedge CLK);
        assert (scl == 1'b1 && sda === 1'b1 && !busy)
        else
        begin
            errs++;
            $display("bus did not return to idle after a missing acknowledge");
        end
        respond = 1'b1;
        end_test("nack", e);

        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
